// ==== logic/cpu_pkg.sv ====
// shared widths, opcodes and host map; opcode_t values are the top 3 bits of every instruction
`default_nettype none

package cpu_pkg;

  // core datapath widths
  localparam int pc_width       = 6;   // 64-word program ROM
  localparam int instr_width    = 9;   // {opcode, a, b}
  localparam int data_width     = 8;
  localparam int reg_addr_width = 3;   // eight registers
  localparam int mem_addr_width = 8;   // 256-byte data memory

  // instruction set, 3-bit opcode field
  typedef enum logic [2:0] {
    op_ldi  = 3'd0,  // ra <- const[b]
    op_ld   = 3'd1,  // ra <- mem[rb]
    op_st   = 3'd2,  // mem[rb] <- ra
    op_add  = 3'd3,  // ra <- ra + rb
    op_sub  = 3'd4,  // ra <- ra - rb
    op_xor  = 3'd5,  // ra <- ra ^ rb
    op_bnz  = 3'd6,  // pc <- target[b] if ra != 0
    op_halt = 3'd7
  } opcode_t;

  // host bus
  localparam int axi_addr_width = 12;
  localparam int axi_data_width = 32;

  // control/status register; write bit 0 = start, read {busy, done}
  localparam logic [axi_addr_width-1:0] host_ctrl_addr = 12'h100;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // program layout in data memory
  localparam logic [data_width-1:0] block_len       = 8'd16;  // input bytes at 0..15
  localparam logic [data_width-1:0] result_sum_addr = 8'd16;
  localparam logic [data_width-1:0] result_xor_addr = 8'd17;

  // first instruction of the summing loop, branch target
  localparam logic [pc_width-1:0] loop_top = 6'd5;

endpackage

`default_nettype wire

// ==== logic/pc.sv ====
// program counter; start wins over everything but reset, holds while halted or idle
`timescale 1ns/1ns
`default_nettype none

module pc (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,      // one-cycle restart pulse
  input  logic                          halt,
  input  logic                          run,
  input  logic                          branch_en,  // absolute jump
  input  logic [cpu_pkg::pc_width-1:0]  target,
  output logic [cpu_pkg::pc_width-1:0]  prog_ctr
);

  always_ff @(posedge clk) begin
    if (reset || start) begin
      prog_ctr <= '0;
    end else if (run && !halt) begin
      if (branch_en)
        prog_ctr <= target;          // taken bnz
      else
        prog_ctr <= prog_ctr + 1;
    end
    // otherwise hold, halt keeps pc on the halt word
  end

endmodule

`default_nettype wire

// ==== logic/instr_rom.sv ====
// fixed program plus branch-target and constant tables, all combinational, unused words halt
`timescale 1ns/1ns
`default_nettype none

module instr_rom (
  input  logic [cpu_pkg::pc_width-1:0]    prog_ctr,
  input  logic [2:0]                      target_sel,
  input  logic [2:0]                      const_sel,
  output logic [cpu_pkg::instr_width-1:0] mach_code,
  output logic [cpu_pkg::pc_width-1:0]    target,
  output logic [cpu_pkg::data_width-1:0]  const_val
);

  // r0 pointer, r1 sum, r2 xor, r3 count, r4 one, r5 loaded byte, r6 result address
  always_comb begin
    case (prog_ctr)
      6'd0:    mach_code = {cpu_pkg::op_ldi,  3'd0, 3'd0};  // r0 = 0
      6'd1:    mach_code = {cpu_pkg::op_ldi,  3'd1, 3'd0};  // sum = 0
      6'd2:    mach_code = {cpu_pkg::op_ldi,  3'd2, 3'd0};  // xor = 0
      6'd3:    mach_code = {cpu_pkg::op_ldi,  3'd3, 3'd2};  // count = block_len
      6'd4:    mach_code = {cpu_pkg::op_ldi,  3'd4, 3'd1};  // step of one
      6'd5:    mach_code = {cpu_pkg::op_ld,   3'd5, 3'd0};  // loop top, r5 = mem[r0]
      6'd6:    mach_code = {cpu_pkg::op_add,  3'd1, 3'd5};
      6'd7:    mach_code = {cpu_pkg::op_xor,  3'd2, 3'd5};
      6'd8:    mach_code = {cpu_pkg::op_add,  3'd0, 3'd4};  // next byte
      6'd9:    mach_code = {cpu_pkg::op_sub,  3'd3, 3'd4};
      6'd10:   mach_code = {cpu_pkg::op_bnz,  3'd3, 3'd0};  // back to loop top
      6'd11:   mach_code = {cpu_pkg::op_ldi,  3'd6, 3'd2};  // sum address
      6'd12:   mach_code = {cpu_pkg::op_st,   3'd1, 3'd6};
      6'd13:   mach_code = {cpu_pkg::op_ldi,  3'd6, 3'd3};  // xor address
      6'd14:   mach_code = {cpu_pkg::op_st,   3'd2, 3'd6};
      default: mach_code = {cpu_pkg::op_halt, 3'd0, 3'd0};
    endcase
  end

  // branch targets, only entry 0 in use
  always_comb begin
    case (target_sel)
      3'd0:    target = cpu_pkg::loop_top;
      default: target = '0;
    endcase
  end

  // constants for ldi
  always_comb begin
    case (const_sel)
      3'd0:    const_val = 8'd0;
      3'd1:    const_val = 8'd1;
      3'd2:    const_val = cpu_pkg::block_len;  // doubles as sum address
      3'd3:    const_val = cpu_pkg::result_xor_addr;
      default: const_val = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/control.sv ====
// instruction decoder; every write, the branch and halt are gated by run so an idle core is inert
`timescale 1ns/1ns
`default_nettype none

module control (
  input  logic [cpu_pkg::instr_width-1:0]    mach_code,
  input  logic [cpu_pkg::data_width-1:0]     rd_data_a,  // register a, for bnz test
  input  logic [cpu_pkg::data_width-1:0]     mem_out,
  input  logic [cpu_pkg::data_width-1:0]     alu_rslt,
  input  logic [cpu_pkg::data_width-1:0]     const_val,
  input  logic                               run,
  output logic [cpu_pkg::reg_addr_width-1:0] reg_a,
  output logic [cpu_pkg::reg_addr_width-1:0] reg_b,
  output logic                               reg_wr_en,
  output logic                               mem_wr_en,
  output logic                               branch_en,
  output logic                               halt,
  output cpu_pkg::opcode_t                   alu_op,
  output logic [2:0]                         target_sel,
  output logic [2:0]                         const_sel,
  output logic [cpu_pkg::data_width-1:0]     wr_data
);

  cpu_pkg::opcode_t opcode;
  logic             writes_reg;

  // field split, {op[8:6], a[5:3], b[2:0]}
  assign opcode = cpu_pkg::opcode_t'(mach_code[8:6]);
  assign reg_a  = mach_code[5:3];
  assign reg_b  = mach_code[2:0];

  // b field also indexes both tables
  assign target_sel = mach_code[2:0];
  assign const_sel  = mach_code[2:0];

  assign alu_op = opcode;

  always_comb begin
    case (opcode)
      cpu_pkg::op_ldi,
      cpu_pkg::op_ld,
      cpu_pkg::op_add,
      cpu_pkg::op_sub,
      cpu_pkg::op_xor: writes_reg = 1'b1;
      default:         writes_reg = 1'b0;  // st, bnz, halt
    endcase
  end

  // write-back source
  always_comb begin
    case (opcode)
      cpu_pkg::op_ldi: wr_data = const_val;
      cpu_pkg::op_ld:  wr_data = mem_out;
      default:         wr_data = alu_rslt;
    endcase
  end

  assign reg_wr_en = run && writes_reg;
  assign mem_wr_en = run && (opcode == cpu_pkg::op_st);
  assign branch_en = run && (opcode == cpu_pkg::op_bnz) && (rd_data_a != '0);
  assign halt      = run && (opcode == cpu_pkg::op_halt);

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// eight registers, contents undefined after reset until the program loads them
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                               clk,
  input  logic [cpu_pkg::reg_addr_width-1:0] reg_a,    // read a and write pointer
  input  logic [cpu_pkg::reg_addr_width-1:0] reg_b,
  input  logic                               wr_en,
  input  logic [cpu_pkg::data_width-1:0]     wr_data,
  output logic [cpu_pkg::data_width-1:0]     dat_a,
  output logic [cpu_pkg::data_width-1:0]     dat_b
);

  logic [cpu_pkg::data_width-1:0] regs [2**cpu_pkg::reg_addr_width];

  // combinational reads
  assign dat_a = regs[reg_a];
  assign dat_b = regs[reg_b];

  always_ff @(posedge clk) begin
    if (wr_en)
      regs[reg_a] <= wr_data;  // destination is always a
  end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// 8-bit alu, add and sub wrap with no carry out, other opcodes pass in_a
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  cpu_pkg::opcode_t               alu_op,
  input  logic [cpu_pkg::data_width-1:0] in_a,
  input  logic [cpu_pkg::data_width-1:0] in_b,
  output logic [cpu_pkg::data_width-1:0] rslt
);

  always_comb begin
    case (alu_op)
      cpu_pkg::op_add: begin
        rslt = in_a + in_b;  // mod 256
      end
      cpu_pkg::op_sub: begin
        rslt = in_a - in_b;  // count down
      end
      cpu_pkg::op_xor: begin
        rslt = in_a ^ in_b;
      end
      default: begin
        rslt = in_a;  // ldi, ld, st, bnz and halt, unused by write-back
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/dat_mem.sv ====
// 256-byte memory, one port shared by core and host by host_own, async read, no reset
`timescale 1ns/1ns
`default_nettype none

module dat_mem (
  input  logic                               clk,
  input  logic                               host_own,   // 1 while core idle
  input  logic [cpu_pkg::mem_addr_width-1:0] core_addr,
  input  logic                               core_wr_en,
  input  logic [cpu_pkg::data_width-1:0]     core_wdata,
  input  logic [cpu_pkg::mem_addr_width-1:0] host_addr,
  input  logic                               host_wr_en,
  input  logic [cpu_pkg::data_width-1:0]     host_wdata,
  output logic [cpu_pkg::data_width-1:0]     rdata
);

  logic [cpu_pkg::data_width-1:0]     mem [2**cpu_pkg::mem_addr_width];
  logic [cpu_pkg::mem_addr_width-1:0] addr;
  logic                               wr_en;
  logic [cpu_pkg::data_width-1:0]     wdata;

  // port owner mux
  assign addr  = host_own ? host_addr  : core_addr;
  assign wr_en = host_own ? host_wr_en : core_wr_en;
  assign wdata = host_own ? host_wdata : core_wdata;

  assign rdata = mem[addr];  // core ld and host read

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[addr] <= wdata;
  end

endmodule

`default_nettype wire

// ==== logic/host_port.sv ====
// axi4-lite slave, one outstanding write and read, wstrb ignored, memory window is 64 bytes
`timescale 1ns/1ns
`default_nettype none

module host_port (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [cpu_pkg::axi_addr_width-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [cpu_pkg::axi_data_width-1:0] wdata,
  input  logic [cpu_pkg::axi_data_width/8-1:0] wstrb,  // full words only
  input  logic                               wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [cpu_pkg::axi_addr_width-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [cpu_pkg::axi_data_width-1:0] rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready,
  input  logic                               halt,
  input  logic [cpu_pkg::data_width-1:0]     mem_rdata,
  output logic                               start,
  output logic                               run,
  output logic [cpu_pkg::mem_addr_width-1:0] mem_addr,
  output logic                               mem_wr_en,
  output logic [cpu_pkg::data_width-1:0]     mem_wdata
);

  logic                               wr_acc, rd_acc;  // handshake cycles
  logic                               wr_go, rd_go;
  logic                               busy, done;
  logic                               aw_mem, aw_ctrl, ar_mem, ar_ctrl;
  logic [cpu_pkg::axi_data_width-1:0] rd_word;

  assign aw_mem  = awaddr < cpu_pkg::host_ctrl_addr;
  assign aw_ctrl = awaddr == cpu_pkg::host_ctrl_addr;
  assign ar_mem  = araddr < cpu_pkg::host_ctrl_addr;
  assign ar_ctrl = araddr == cpu_pkg::host_ctrl_addr;

  // write and read handshakes never share a cycle, memory port has one address
  assign wr_go = awvalid && wvalid && !bvalid && !wr_acc && !rd_acc;
  assign rd_go = arvalid && !rvalid && !rd_acc && !wr_acc && !wr_go;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_acc <= 1'b0;
      rd_acc <= 1'b0;
    end else begin
      wr_acc <= wr_go;  // one-cycle ready pulse
      rd_acc <= rd_go;
    end
  end

  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;

  // start ignored while running
  assign start     = wr_acc && aw_ctrl && wdata[0] && !busy;
  assign run       = busy;
  assign mem_wr_en = wr_acc && aw_mem && !busy;  // dropped while busy
  assign mem_addr  = wr_acc ? awaddr[cpu_pkg::mem_addr_width+1:2]
                            : araddr[cpu_pkg::mem_addr_width+1:2];
  assign mem_wdata = wdata[cpu_pkg::data_width-1:0];

  // run state
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;  // cleared by the next run
    end else if (halt) begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

  // write response
  always_ff @(posedge clk) begin
    if (reset)
      bvalid <= 1'b0;
    else if (wr_acc)
      bvalid <= 1'b1;
    else if (bready)
      bvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (wr_acc)
      bresp <= (aw_ctrl || (aw_mem && !busy)) ? cpu_pkg::resp_okay : cpu_pkg::resp_slverr;
  end

  // read data, zero when refused or unmapped
  always_comb begin
    rd_word = '0;
    if (ar_ctrl)
      rd_word[1:0] = {busy, done};
    else if (ar_mem && !busy)
      rd_word[cpu_pkg::data_width-1:0] = mem_rdata;
  end

  always_ff @(posedge clk) begin
    if (reset)
      rvalid <= 1'b0;
    else if (rd_acc)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rdata <= rd_word;  // holds until the next accepted read
      rresp <= (ar_ctrl || (ar_mem && !busy)) ? cpu_pkg::resp_okay : cpu_pkg::resp_slverr;
    end
  end

endmodule

`default_nettype wire

// ==== logic/top_level.sv ====
// 8-bit core with axi4-lite host port; host owns data memory whenever the core is idle
`timescale 1ns/1ns
`default_nettype none

module top_level (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [cpu_pkg::axi_addr_width-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [cpu_pkg::axi_data_width-1:0] wdata,
  input  logic [cpu_pkg::axi_data_width/8-1:0] wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [cpu_pkg::axi_addr_width-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [cpu_pkg::axi_data_width-1:0] rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready
);

  logic [cpu_pkg::pc_width-1:0]       prog_ctr, target;
  logic [cpu_pkg::instr_width-1:0]    mach_code;
  logic [2:0]                         target_sel, const_sel;
  logic [cpu_pkg::data_width-1:0]     const_val, wr_data, alu_rslt;
  logic [cpu_pkg::data_width-1:0]     dat_a, dat_b, mem_rdata;
  logic [cpu_pkg::reg_addr_width-1:0] reg_a, reg_b;
  logic                               reg_wr_en, mem_wr_en, branch_en, halt;
  cpu_pkg::opcode_t                   alu_op;
  logic                               start, run;
  logic [cpu_pkg::mem_addr_width-1:0] host_addr;
  logic                               host_wr_en;
  logic [cpu_pkg::data_width-1:0]     host_wdata;

  pc pc_i (
    .clk, .reset, .start, .halt, .run, .branch_en, .target, .prog_ctr
  );

  instr_rom rom_i (
    .prog_ctr, .target_sel, .const_sel, .mach_code, .target, .const_val
  );

  control ctl_i (
    .mach_code, .rd_data_a (dat_a), .mem_out (mem_rdata), .alu_rslt, .const_val, .run,
    .reg_a, .reg_b, .reg_wr_en, .mem_wr_en, .branch_en, .halt, .alu_op,
    .target_sel, .const_sel, .wr_data
  );

  reg_file rf_i (
    .clk, .reg_a, .reg_b, .wr_en (reg_wr_en), .wr_data, .dat_a, .dat_b
  );

  alu alu_i (
    .alu_op, .in_a (dat_a), .in_b (dat_b), .rslt (alu_rslt)
  );

  // core addresses memory through rb, stores ra
  dat_mem dm_i (
    .clk, .host_own (!run),
    .core_addr (dat_b), .core_wr_en (mem_wr_en), .core_wdata (dat_a),
    .host_addr, .host_wr_en, .host_wdata, .rdata (mem_rdata)
  );

  host_port hp_i (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .halt, .mem_rdata, .start, .run,
    .mem_addr (host_addr), .mem_wr_en (host_wr_en), .mem_wdata (host_wdata)
  );

endmodule

`default_nettype wire

// ==== testbench/top_level_props.sv ====
// host-port handshake checks, bound into host_port; violations is read by the testbench at the end
`timescale 1ns/1ns
`default_nettype none

module top_level_props (
  input logic                               clk,
  input logic                               reset,
  input logic [cpu_pkg::axi_addr_width-1:0] awaddr,
  input logic                               awready,
  input logic                               bvalid,
  input logic                               bready,
  input logic [1:0]                         bresp,
  input logic                               rvalid,
  input logic                               rready,
  input logic [cpu_pkg::axi_data_width-1:0] rdata,
  input logic                               mem_wr_en,  // host side only
  input logic                               run         // busy
);

  int unsigned violations = 0;

  // write response parked until taken
  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      violations++;
      $error("bvalid or bresp changed before bready");
    end

  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      violations++;
      $error("rvalid or rdata changed before rready");
    end

  // core owns the memory port while running, window writes refused
  mem_own: assert property (@(posedge clk) disable iff (reset)
    awready && awaddr < cpu_pkg::host_ctrl_addr && run
      |=> !$past(mem_wr_en) && bvalid && bresp == cpu_pkg::resp_slverr)
    else begin
      violations++;
      $error("host memory write while the core is busy was not refused");
    end

endmodule

`default_nettype wire

// ==== testbench/top_level_tb.sv ====
// run from the project root so testbench/top_level_testdata.txt resolves; inputs change on the falling edge
`timescale 1ns/1ns
`default_nettype none

module top_level_tb;

  logic                                 clk = 1'b0;
  logic                                 reset;
  logic [cpu_pkg::axi_addr_width-1:0]   awaddr, araddr;
  logic [cpu_pkg::axi_data_width-1:0]   wdata, rdata;
  logic [cpu_pkg::axi_data_width/8-1:0] wstrb;
  logic                                 awvalid, wvalid, bready, arvalid, rready;
  logic                                 awready, wready, bvalid, arready, rvalid;
  logic [1:0]                           bresp, rresp;

  logic [31:0] lfsr_state = 32'h8c6;  // stall generator
  int unsigned error_count = 0;
  int unsigned check_count = 0;
  bit          aborted = 1'b0;        // set by a timeout or a bad data file

  top_level dut_i (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  // protocol checks ride along inside the host port
  bind host_port top_level_props props_i (
    .clk, .reset, .awaddr, .awready, .bvalid, .bready, .bresp, .rvalid, .rready, .rdata,
    .mem_wr_en, .run
  );

  always #4 clk = ~clk;  // 8 ns

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32,22,2,1
  endfunction

  // two bits, one step each, gives 0..3 ready delay
  function automatic int stall_cycles();
    int n;
    int i;
    n = 0;
    for (i = 0; i < 2; i++) begin
      n = (n << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
    return n;
  endfunction

  // byte address into the memory window, one word per byte
  function automatic logic [cpu_pkg::axi_addr_width-1:0] mem_axi_addr(input logic [7:0] b);
    return {2'b00, b, 2'b00};
  endfunction

  task automatic abort_run(input string what);
    error_count++;
    aborted = 1'b1;  // remaining transfers and checks are skipped
    $display("FAILURE at %0t: %s", $time, what);
  endtask

  task automatic check_data(input string name, input logic [cpu_pkg::data_width-1:0] got,
                            input logic [cpu_pkg::data_width-1:0] exp);
    if (aborted) return;
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (aborted) return;
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // {busy, done}
  task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (aborted) return;
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // entered and left on a falling edge
  task automatic axi_write(input logic [cpu_pkg::axi_addr_width-1:0] addr,
                           input logic [cpu_pkg::axi_data_width-1:0] data,
                           output logic [1:0] resp);
    int n;
    int stall;
    resp = 2'b11;
    if (aborted) return;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!awready) begin  // ready pulse comes a cycle after valid
      if (n == 100) begin
        abort_run($sformatf("no awready for write to 0x%h", addr));
        return;
      end
      n++;
      @(negedge clk);
    end
    @(negedge clk);  // handshake on the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) begin
      if (n == 100) begin
        abort_run($sformatf("no bvalid for write to 0x%h", addr));
        return;
      end
      n++;
      @(negedge clk);
    end
    resp  = bresp;
    stall = stall_cycles();
    repeat (stall) @(negedge clk);  // bvalid must hold here
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [cpu_pkg::axi_addr_width-1:0] addr,
                          output logic [cpu_pkg::axi_data_width-1:0] data,
                          output logic [1:0] resp);
    int n;
    int stall;
    data = '0;
    resp = 2'b11;
    if (aborted) return;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!arready) begin
      if (n == 100) begin
        abort_run($sformatf("no arready for read of 0x%h", addr));
        return;
      end
      n++;
      @(negedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      if (n == 100) begin
        abort_run($sformatf("no rvalid for read of 0x%h", addr));
        return;
      end
      n++;
      @(negedge clk);
    end
    data  = rdata;
    resp  = rresp;
    stall = stall_cycles();
    repeat (stall) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // load, verify, run, check results and that inputs survive
  task automatic run_case(input int case_no, input logic [7:0] bytes [16],
                          input logic [7:0] sum_exp, input logic [7:0] xor_exp);
    logic [1:0]                         resp;
    logic [cpu_pkg::axi_data_width-1:0] rd;
    int                                 polls;
    int                                 i;
    for (i = 0; i < 16; i++) begin
      axi_write(mem_axi_addr(8'(i)), {24'h0, bytes[i]}, resp);
      check_resp($sformatf("case %0d bresp mem[%0d]", case_no, i), resp, cpu_pkg::resp_okay);
    end
    for (i = 0; i < 16; i++) begin
      axi_read(mem_axi_addr(8'(i)), rd, resp);
      check_resp($sformatf("case %0d rresp mem[%0d]", case_no, i), resp, cpu_pkg::resp_okay);
      check_data($sformatf("case %0d rdata mem[%0d]", case_no, i), rd[7:0], bytes[i]);
    end
    axi_write(cpu_pkg::host_ctrl_addr, 32'h1, resp);  // start
    check_resp($sformatf("case %0d bresp start", case_no), resp, cpu_pkg::resp_okay);
    axi_read(cpu_pkg::host_ctrl_addr, rd, resp);
    check_resp($sformatf("case %0d rresp status", case_no), resp, cpu_pkg::resp_okay);
    check_status($sformatf("case %0d status after start", case_no), rd[1:0], 2'b10);
    // memory is locked to the core now
    axi_write(mem_axi_addr(8'd3), {24'h0, ~bytes[3]}, resp);
    check_resp($sformatf("case %0d bresp busy write", case_no), resp, cpu_pkg::resp_slverr);
    axi_read(mem_axi_addr(8'd3), rd, resp);
    check_resp($sformatf("case %0d rresp busy read", case_no), resp, cpu_pkg::resp_slverr);
    check_data($sformatf("case %0d rdata busy read", case_no), rd[7:0], 8'h00);
    axi_write(cpu_pkg::host_ctrl_addr, 32'h1, resp);  // ignored, still okay
    check_resp($sformatf("case %0d bresp start busy", case_no), resp, cpu_pkg::resp_okay);
    polls = 0;
    rd = '0;
    while (!aborted && !rd[0]) begin
      axi_read(cpu_pkg::host_ctrl_addr, rd, resp);
      polls++;
      if (!rd[0] && polls == 100)
        abort_run($sformatf("case %0d: done still low after %0d status reads", case_no, polls));
    end
    check_status($sformatf("case %0d status at end", case_no), rd[1:0], 2'b01);
    axi_read(mem_axi_addr(cpu_pkg::result_sum_addr), rd, resp);
    check_resp($sformatf("case %0d rresp sum", case_no), resp, cpu_pkg::resp_okay);
    check_data($sformatf("case %0d sum", case_no), rd[7:0], sum_exp);
    axi_read(mem_axi_addr(cpu_pkg::result_xor_addr), rd, resp);
    check_resp($sformatf("case %0d rresp xor", case_no), resp, cpu_pkg::resp_okay);
    check_data($sformatf("case %0d xor", case_no), rd[7:0], xor_exp);
    for (i = 0; i < 16; i++) begin
      axi_read(mem_axi_addr(8'(i)), rd, resp);
      check_data($sformatf("case %0d mem[%0d] after run", case_no, i), rd[7:0], bytes[i]);
    end
  endtask

  initial begin : main
    string                              line;
    int                                 fd;
    int                                 n;
    int                                 case_no;
    int                                 vals [18];
    logic [7:0]                         in_bytes [16];
    logic [1:0]                         resp;
    logic [cpu_pkg::axi_data_width-1:0] rd;
    int                                 prop_fails;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '1;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    axi_read(cpu_pkg::host_ctrl_addr, rd, resp);  // idle after reset
    check_resp("rresp status after reset", resp, cpu_pkg::resp_okay);
    check_status("status after reset", rd[1:0], 2'b00);

    fd = $fopen("testbench/top_level_testdata.txt", "r");
    if (fd == 0)
      abort_run("cannot open testbench/top_level_testdata.txt");
    case_no = 0;
    while (!aborted && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0)
        continue;
      if (line.len() < 2 || line.getc(0) == "#")
        continue;  // blank or column notes
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  vals[0], vals[1], vals[2], vals[3], vals[4], vals[5],
                  vals[6], vals[7], vals[8], vals[9], vals[10], vals[11],
                  vals[12], vals[13], vals[14], vals[15], vals[16], vals[17]);
      if (n != 18) begin
        abort_run($sformatf("data line %0d has %0d values instead of 18", case_no, n));
      end else begin
        for (int i = 0; i < 16; i++)
          in_bytes[i] = vals[i][7:0];
        run_case(case_no, in_bytes, vals[16][7:0], vals[17][7:0]);  // no reset between
        case_no++;
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (!aborted && case_no == 0)
      abort_run("no test cases found in the data file");

    prop_fails = int'(dut_i.hp_i.props_i.violations);
    $display("cases %0d, checks %0d, errors %0d, assertion failures %0d",
             case_no, check_count, error_count, prop_fails);
    if (error_count == 0 && prop_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/top_level_testdata.txt ====
# columns: sixteen input bytes for data addresses 0 to 15, expected sum mod 256, expected xor
# all values hex, one case per line
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 78 00
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff f0 00
80 40 20 10 08 04 02 01 00 00 00 00 00 00 00 00 ff ff
5a a5 3c c3 01 02 04 08 10 20 40 80 ff 00 11 22 2f 33
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 02 11 03
de ad be ef 00 00 00 00 00 00 00 00 00 00 00 00 38 22
12 34 56 78 9a bc de f0 00 00 00 00 00 00 00 00 38 00

// ==== vlog.f ====
logic/cpu_pkg.sv
logic/pc.sv
logic/instr_rom.sv
logic/control.sv
logic/reg_file.sv
logic/alu.sv
logic/dat_mem.sv
logic/host_port.sv
logic/top_level.sv
testbench/top_level_props.sv
testbench/top_level_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run top_level_tb with Verilator; exit status follows the testbench result
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module top_level_tb

# assertion failures are counted by the testbench, so the run goes on past them
./obj_dir/Vtop_level_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
exit 1
